//--- Makefile
TOP = tb_instructionControl

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing -f list.f --top-module $(TOP) -o simv
	./obj_dir/simv > sim.log 2>&1 || true
	@cat sim.log
	@grep -q "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- addressSequencer.sv
module addressSequencer import opPkg::*, timingPkg::*; (
    input  decodedT          decoded,
    input  logic [stepW-1:0] step,
    input  logic [stepW-1:0] limit,
    input  logic             active,
    output ctrlFlagsT        flags
);

    ctrlFlagsT        seqFlags;
    logic             memMode;
    logic [stepW-1:0] dataStep;
    logic             isRmw;

    assign memMode = decoded.mode inside {ZPG, ZPGX, ZPGY, ABS, ABSX, ABSY, INDX, INDY};
    assign isRmw   = (decoded.iclass == RMW);

    // rmw reads first, then two write cycles
    assign dataStep = isRmw ? limit - 3'd3 : limit - 3'd1;

    always_comb begin
        seqFlags = '0;
        case (decoded.mode)
            IMM, REL: begin
                if (step == 3'd1) seqFlags.pcInc = 1'b1;
            end
            ZPG, ZPGX, ZPGY: begin
                case (step)
                    3'd1: {seqFlags.pcInc, seqFlags.fetchLo} = 2'b11;
                    3'd2: seqFlags.indexAdd = (decoded.mode != ZPG);
                    default: ;
                endcase
            end
            ABS, ABSX, ABSY, IND: begin
                case (step)
                    3'd1: {seqFlags.pcInc, seqFlags.fetchLo} = 2'b11;
                    3'd2: {seqFlags.pcInc, seqFlags.fetchHi} = 2'b11;
                    3'd3: begin
                        seqFlags.indexAdd = (decoded.mode == ABSX || decoded.mode == ABSY);
                        seqFlags.fetchLo  = (decoded.mode == IND);
                    end
                    3'd4: seqFlags.fetchHi = (decoded.mode == IND);
                    default: ;
                endcase
            end
            INDX: begin
                case (step)
                    3'd1: {seqFlags.pcInc, seqFlags.fetchLo} = 2'b11;
                    3'd2: seqFlags.indexAdd = 1'b1;
                    3'd3: seqFlags.fetchLo = 1'b1;
                    3'd4: seqFlags.fetchHi = 1'b1;
                    default: ;
                endcase
            end
            INDY: begin
                // pointer read, then Y added to it
                case (step)
                    3'd1: {seqFlags.pcInc, seqFlags.fetchLo} = 2'b11;
                    3'd2: seqFlags.fetchLo = 1'b1;
                    3'd3: seqFlags.fetchHi = 1'b1;
                    3'd4: seqFlags.indexAdd = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase

        seqFlags.memRead = memMode && (step == dataStep)
            && (decoded.iclass == READ || isRmw);
        seqFlags.memWrite = memMode
            && ((decoded.iclass == WRITE && step == dataStep)
            || (isRmw && step >= limit - 3'd2));
        seqFlags.lastCycle = (step == limit - 3'd1);
    end

    assign flags = active ? seqFlags : '0;

endmodule

//--- decoder.sv
module decoder import opPkg::*, timingPkg::*; (
    input  logic [7:0] opcode,
    output decodedT    decoded
);

    logic [2:0] a;
    logic [2:0] b;
    logic [1:0] c;
    mnemonicT   mn;
    addrModeT   md;
    instrClassT cls;

    assign a = opcode[7:5];
    assign b = opcode[4:2];
    assign c = opcode[1:0];

    always_comb begin
        mn = ILL;
        md = IMPL;
        case (c)
            2'b00: begin
                case (b)
                    3'b000: begin
                        md = STK;
                        case (a)
                            3'd0: mn = BRK;
                            3'd1: begin
                                mn = JSR;
                                md = ABS;
                            end
                            3'd2: mn = RTI;
                            3'd3: mn = RTS;
                            3'd5: begin
                                mn = LDY;
                                md = IMM;
                            end
                            3'd6: begin
                                mn = CPY;
                                md = IMM;
                            end
                            3'd7: begin
                                mn = CPX;
                                md = IMM;
                            end
                            default: mn = ILL;
                        endcase
                    end
                    3'b001: begin
                        md = ZPG;
                        case (a)
                            3'd1: mn = BIT;
                            3'd4: mn = STY;
                            3'd5: mn = LDY;
                            3'd6: mn = CPY;
                            3'd7: mn = CPX;
                            default: mn = ILL;
                        endcase
                    end
                    3'b010: begin
                        // stack ops in the low half
                        md = a[2] ? IMPL : STK;
                        case (a)
                            3'd0: mn = PHP;
                            3'd1: mn = PLP;
                            3'd2: mn = PHA;
                            3'd3: mn = PLA;
                            3'd4: mn = DEY;
                            3'd5: mn = TAY;
                            3'd6: mn = INY;
                            default: mn = INX;
                        endcase
                    end
                    3'b011: begin
                        md = ABS;
                        case (a)
                            3'd1: mn = BIT;
                            3'd2: mn = JMP;
                            3'd3: begin
                                mn = JMP;
                                md = IND;
                            end
                            3'd4: mn = STY;
                            3'd5: mn = LDY;
                            3'd6: mn = CPY;
                            3'd7: mn = CPX;
                            default: mn = ILL;
                        endcase
                    end
                    3'b100: begin
                        md = REL;
                        case (a)
                            3'd0: mn = BPL;
                            3'd1: mn = BMI;
                            3'd2: mn = BVC;
                            3'd3: mn = BVS;
                            3'd4: mn = BCC;
                            3'd5: mn = BCS;
                            3'd6: mn = BNE;
                            default: mn = BEQ;
                        endcase
                    end
                    3'b101: begin
                        md = ZPGX;
                        if (a == 3'd4) mn = STY;
                        else if (a == 3'd5) mn = LDY;
                    end
                    3'b110: begin
                        case (a)
                            3'd0: mn = CLC;
                            3'd1: mn = SEC;
                            3'd2: mn = CLI;
                            3'd3: mn = SEI;
                            3'd4: mn = TYA;
                            3'd5: mn = CLV;
                            3'd6: mn = CLD;
                            default: mn = SED;
                        endcase
                    end
                    default: begin
                        md = ABSX;
                        if (a == 3'd5) mn = LDY;
                    end
                endcase
            end
            2'b01: begin
                // mode follows b directly in this group
                case (b)
                    3'd0: md = INDX;
                    3'd1: md = ZPG;
                    3'd2: md = IMM;
                    3'd3: md = ABS;
                    3'd4: md = INDY;
                    3'd5: md = ZPGX;
                    3'd6: md = ABSY;
                    default: md = ABSX;
                endcase
                case (a)
                    3'd0: mn = ORA;
                    3'd1: mn = AND;
                    3'd2: mn = EOR;
                    3'd3: mn = ADC;
                    3'd4: mn = (b == 3'd2) ? ILL : STA;
                    3'd5: mn = LDA;
                    3'd6: mn = CMP;
                    default: mn = SBC;
                endcase
            end
            2'b10: begin
                case (a)
                    3'd0: mn = ASL;
                    3'd1: mn = ROL;
                    3'd2: mn = LSR;
                    3'd3: mn = ROR;
                    3'd4: mn = STX;
                    3'd5: mn = LDX;
                    3'd6: mn = DEC;
                    default: mn = INC;
                endcase
                case (b)
                    3'b000: begin
                        md = IMM;
                        if (a != 3'd5) mn = ILL;
                    end
                    3'b001: md = ZPG;
                    3'b010: begin
                        md = a[2] ? IMPL : ACC;
                        if (a == 3'd4) mn = TXA;
                        else if (a == 3'd5) mn = TAX;
                        else if (a == 3'd6) mn = DEX;
                        else if (a == 3'd7) mn = NOP;
                    end
                    3'b011: md = ABS;
                    3'b101: md = (a == 3'd4 || a == 3'd5) ? ZPGY : ZPGX;
                    3'b110: begin
                        if (a == 3'd4) mn = TXS;
                        else if (a == 3'd5) mn = TSX;
                        else mn = ILL;
                    end
                    3'b111: begin
                        // no STX abs,Y on this part
                        md = (a == 3'd5) ? ABSY : ABSX;
                        if (a == 3'd4) mn = ILL;
                    end
                    default: mn = ILL;
                endcase
            end
            default: mn = ILL;
        endcase
    end

    always_comb begin
        case (mn)
            LDA, LDX, LDY, ADC, AND, EOR, ORA, SBC, CMP, CPX, CPY, BIT: cls = READ;
            STA, STX, STY: cls = WRITE;
            ASL, LSR, ROL, ROR: cls = (md == ACC) ? IMPLIED : RMW;
            INC, DEC: cls = RMW;
            BCC, BCS, BEQ, BMI, BNE, BPL, BVC, BVS: cls = BRANCH;
            JMP, JSR: cls = JUMP;
            BRK, RTI, RTS, PHA, PHP, PLA, PLP: cls = STACK;
            ILL: cls = ILLEGAL;
            default: cls = IMPLIED;
        endcase
    end

    assign decoded.mnemonic = mn;
    assign decoded.mode     = (mn == ILL) ? IMPL : md;
    assign decoded.iclass   = cls;
    assign decoded.illegal  = (mn == ILL);

endmodule

//--- instructionControl.sv
module instructionControl import opPkg::*, timingPkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             fetch,
    input  logic [7:0]       opcode,
    output decodedT          decoded,
    output ctrlFlagsT        flags,
    output logic [stepW-1:0] step,
    output logic             active
);

    logic [7:0]       opReg;
    logic [stepW-1:0] limit;

    decoder i_decoder (
        .opcode  (opReg),
        .decoded (decoded)
    );

    // base count from the mode table, then class exceptions
    always_comb begin
        limit = cycleCount[decoded.mode];
        if (decoded.iclass == RMW) begin
            limit = limit + 3'd2;
        end else if (decoded.iclass == JUMP && decoded.mode == ABS) begin
            limit = 3'd3;
        end
    end

    addressSequencer i_addressSequencer (
        .decoded (decoded),
        .step    (step),
        .limit   (limit),
        .active  (active),
        .flags   (flags)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            opReg  <= 8'hEA;
            step   <= '0;
            active <= 1'b0;
        end else if (fetch) begin
            // new opcode wins, even mid-instruction
            opReg  <= opcode;
            step   <= 3'd1;
            active <= 1'b1;
        end else if (active) begin
            if (flags.lastCycle) active <= 1'b0;
            else step <= step + 3'd1;
        end
    end

endmodule

//--- list.f
+incdir+.
timingPkg.sv
opPkg.sv
decoder.sv
addressSequencer.sv
instructionControl.sv
tbClock.sv
tb_instructionControl.sv

//--- opPkg.sv
package opPkg;

    import timingPkg::*;

    // documented 6502 mnemonics, ILL for everything else
    typedef enum logic [5:0] {
        ADC, AND, ASL, BCC, BCS, BEQ, BIT, BMI,
        BNE, BPL, BRK, BVC, BVS, CLC, CLD, CLI,
        CLV, CMP, CPX, CPY, DEC, DEX, DEY, EOR,
        INC, INX, INY, JMP, JSR, LDA, LDX, LDY,
        LSR, NOP, ORA, PHA, PHP, PLA, PLP, ROL,
        ROR, RTI, RTS, SBC, SEC, SED, SEI, STA,
        STX, STY, TAX, TAY, TSX, TXA, TXS, TYA,
        ILL
    } mnemonicT;

    // what the data cycle does
    typedef enum logic [2:0] {
        READ    = 3'd0,
        WRITE   = 3'd1,
        RMW     = 3'd2,
        BRANCH  = 3'd3,
        JUMP    = 3'd4,
        STACK   = 3'd5,
        IMPLIED = 3'd6,
        ILLEGAL = 3'd7
    } instrClassT;

    typedef struct packed {
        mnemonicT   mnemonic;
        addrModeT   mode;
        instrClassT iclass;
        logic       illegal;
    } decodedT;

endpackage

//--- tbClock.sv
module tbClock (
    output logic clk
);

    // free-running, period 40
    initial clk = 1'b0;

    always #20 clk = ~clk;

endmodule

//--- tbDecodeModel.svh
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// 6502 opcode matrix, one array per low nibble, indexed by the high nibble
localparam mnemonicT colX0 [16] = '{
    BRK, BPL, JSR, BMI, RTI, BVC, RTS, BVS, ILL, BCC, LDY, BCS, CPY, BNE, CPX, BEQ
};
// columns 1, 5, 9 and D share the accumulator group
localparam mnemonicT aluRow [16] = '{
    ORA, ORA, AND, AND, EOR, EOR, ADC, ADC, STA, STA, LDA, LDA, CMP, CMP, SBC, SBC
};
localparam mnemonicT colX4 [16] = '{
    ILL, ILL, BIT, ILL, ILL, ILL, ILL, ILL, STY, STY, LDY, LDY, CPY, ILL, CPX, ILL
};
localparam mnemonicT colX6 [16] = '{
    ASL, ASL, ROL, ROL, LSR, LSR, ROR, ROR, STX, STX, LDX, LDX, DEC, DEC, INC, INC
};
localparam mnemonicT colX8 [16] = '{
    PHP, CLC, PLP, SEC, PHA, CLI, PLA, SEI, DEY, TYA, TAY, CLV, INY, CLD, INX, SED
};
localparam mnemonicT colXA [16] = '{
    ASL, ILL, ROL, ILL, LSR, ILL, ROR, ILL, TXA, TXS, TAX, TSX, DEX, ILL, NOP, ILL
};
localparam mnemonicT colXC [16] = '{
    ILL, ILL, BIT, ILL, JMP, ILL, JMP, ILL, STY, ILL, LDY, LDY, CPY, ILL, CPX, ILL
};
localparam mnemonicT colXE [16] = '{
    ASL, ASL, ROL, ROL, LSR, LSR, ROR, ROR, STX, ILL, LDX, LDX, DEC, DEC, INC, INC
};

// usual mode of each column for even and odd high nibbles
localparam addrModeT evenMode [16] = '{
    IMM, INDX, IMM, IMPL, ZPG, ZPG, ZPG, IMPL, IMPL, IMM, IMPL, IMPL, ABS, ABS, ABS, IMPL
};
localparam addrModeT oddMode [16] = '{
    REL, INDY, IMPL, IMPL, ZPGX, ZPGX, ZPGX, IMPL, IMPL, ABSY, IMPL, IMPL, ABSX, ABSX, ABSX, IMPL
};

function automatic mnemonicT mnemonicOf(input logic [7:0] op);
    logic [3:0] r;
    r = op[7:4];
    case (op[3:0])
        4'h0: return colX0[r];
        4'h1, 4'h5, 4'hD: return aluRow[r];
        4'h2: return (op == 8'hA2) ? LDX : ILL;
        4'h4: return colX4[r];
        4'h6: return colX6[r];
        4'h8: return colX8[r];
        4'h9: return (op == 8'h89) ? ILL : aluRow[r];
        4'hA: return colXA[r];
        4'hC: return colXC[r];
        4'hE: return colXE[r];
        default: return ILL;
    endcase
endfunction

function automatic addrModeT modeOf(input logic [7:0] op, input mnemonicT mn);
    addrModeT md;
    md = op[4] ? oddMode[op[3:0]] : evenMode[op[3:0]];
    case (mn)
        ILL: md = IMPL;
        BRK, RTI, RTS, PHA, PHP, PLA, PLP: md = STK;
        JSR: md = ABS;
        ASL, LSR, ROL, ROR: begin
            if (op[3:0] == 4'hA) md = ACC;
        end
        STX, LDX: begin
            // X loads and stores index with Y
            if (md == ZPGX) md = ZPGY;
            if (md == ABSX) md = ABSY;
        end
        default: ;
    endcase
    if (op == 8'h6C) md = IND;
    return md;
endfunction

function automatic instrClassT classOf(input mnemonicT mn, input addrModeT md);
    case (mn)
        LDA, LDX, LDY, ADC, AND, EOR, ORA, SBC, CMP, CPX, CPY, BIT: return READ;
        STA, STX, STY: return WRITE;
        ASL, LSR, ROL, ROR: return (md == ACC) ? IMPLIED : RMW;
        INC, DEC: return RMW;
        BCC, BCS, BEQ, BMI, BNE, BPL, BVC, BVS: return BRANCH;
        JMP, JSR: return JUMP;
        BRK, RTI, RTS, PHA, PHP, PLA, PLP: return STACK;
        ILL: return ILLEGAL;
        default: return IMPLIED;
    endcase
endfunction

function automatic int cycleLimit(input addrModeT md, input instrClassT cls);
    int n;
    case (md)
        IMPL, ACC, IMM, REL: n = 2;
        ZPG, STK: n = 3;
        IND, INDY: n = 5;
        INDX: n = 6;
        default: n = 4;
    endcase
    if (cls == RMW) n = n + 2;
    else if (cls == JUMP && md == ABS) n = 3;
    return n;
endfunction

`endif

//--- tb_instructionControl.sv
module tb_instructionControl import opPkg::*, timingPkg::*;;

    localparam int sweepCount  = 256;
    localparam int randomCount = 2000;

    logic             clk;
    logic             rst;
    logic             fetch;
    logic [7:0]       opcode;
    decodedT          decoded;
    ctrlFlagsT        flags;
    logic [stepW-1:0] step;
    logic             active;

    logic [15:0] lfsr;
    int          pulses;
    int          completed;
    int          illegalSeen;

    `include "tbDecodeModel.svh"

    tbClock i_tbClock (
        .clk (clk)
    );

    instructionControl i_instructionControl (
        .clk     (clk),
        .rst     (rst),
        .fetch   (fetch),
        .opcode  (opcode),
        .decoded (decoded),
        .flags   (flags),
        .step    (step),
        .active  (active)
    );

    function automatic logic [15:0] lfsrStep(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one LFSR step per bit taken
    task automatic randomBits(input int n, output logic [7:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);
            v = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        if (got !== expected) begin
            abortRun($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                               name, got, expected));
        end
    endtask

    // inputs change and outputs are sampled 5 units after the edge
    task automatic tick();
        @(posedge clk);
        #5;
    endtask

    task automatic idleFor(input int n);
        logic [stepW-1:0] held;
        int i;
        held = step;
        for (i = 0; i < n; i++) begin
            check("active", 32'(active), 32'd0);
            check("flags", 32'(flags), 32'd0);
            check("step", 32'(step), 32'(held));
            tick();
        end
    endtask

    task automatic executeOpcode(input logic [7:0] op, input logic cut, output logic done);
        mnemonicT   mn;
        addrModeT   md;
        instrClassT cls;
        int         lim;
        int         cyc;
        mn   = mnemonicOf(op);
        md   = modeOf(op, mn);
        cls  = classOf(mn, md);
        lim  = cycleLimit(md, cls);
        done = 1'b0;
        fetch  = 1'b1;
        opcode = op;
        tick();
        fetch  = 1'b0;
        opcode = ~op;
        check("active", 32'(active), 32'd1);
        cyc = 0;
        while (active === 1'b1) begin
            cyc++;
            check("step", 32'(step), 32'(cyc));
            check("decoded.mnemonic", 32'(decoded.mnemonic), 32'(mn));
            check("decoded.mode", 32'(decoded.mode), 32'(md));
            check("decoded.iclass", 32'(decoded.iclass), 32'(cls));
            check("decoded.illegal", 32'(decoded.illegal), 32'(mn == ILL));
            check("flags.lastCycle", 32'(flags.lastCycle), 32'(cyc == lim - 1));
            if (cls != WRITE && cls != RMW) begin
                check("flags.memWrite", 32'(flags.memWrite), 32'd0);
            end
            if (cls == WRITE) begin
                check("flags.memRead", 32'(flags.memRead), 32'd0);
            end
            // next fetch goes out while this one is still running
            if (cut && cyc == 1 && lim > 2) return;
            tick();
        end
        check("active cycles", 32'(cyc), 32'(lim - 1));
        done = 1'b1;
    endtask

    always @(negedge clk) begin
        if (flags.lastCycle === 1'b1) pulses++;
    end

    initial begin
        #((sweepCount + randomCount) * 10 * 40 + 100 * 40);
        abortRun("timeout: the instruction stream did not finish in time");
    end

    initial begin
        logic       done;
        logic       cut;
        logic [7:0] op;
        logic [7:0] r;
        int         k;
        rst         = 1'b1;
        fetch       = 1'b0;
        opcode      = 8'h00;
        lfsr        = 16'd30;
        pulses      = 0;
        completed   = 0;
        illegalSeen = 0;
        repeat (4) @(posedge clk);
        #5;
        rst = 1'b0;

        // quiet after reset, opReg back to NOP
        repeat (6) begin
            check("active", 32'(active), 32'd0);
            check("step", 32'(step), 32'd0);
            check("flags", 32'(flags), 32'd0);
            check("decoded.mnemonic", 32'(decoded.mnemonic), 32'(NOP));
            tick();
        end

        for (k = 0; k < sweepCount; k++) begin
            executeOpcode(8'(k), 1'b0, done);
            completed++;
            illegalSeen += int'(decoded.illegal);
            idleFor(1);
        end
        // 151 documented opcodes
        check("illegal opcode count", 32'(illegalSeen), 32'd105);

        for (k = 0; k < randomCount; k++) begin
            randomBits(8, op);
            randomBits(3, r);
            cut = (r == 8'd0);
            executeOpcode(op, cut, done);
            if (done) begin
                completed++;
                randomBits(2, r);
                idleFor(int'(r));
            end
        end

        check("lastCycle pulses", 32'(pulses), 32'(completed));
        $display("Verification passed");
        $finish;
    end

endmodule

//--- timingPkg.sv
package timingPkg;

    // step counter width, enough for the longest instruction
    localparam int stepW = 3;

    typedef enum logic [3:0] {
        IMPL = 4'd0,
        ACC  = 4'd1,
        IMM  = 4'd2,
        ZPG  = 4'd3,
        ZPGX = 4'd4,
        ZPGY = 4'd5,
        ABS  = 4'd6,
        ABSX = 4'd7,
        ABSY = 4'd8,
        IND  = 4'd9,
        INDX = 4'd10,
        INDY = 4'd11,
        REL  = 4'd12,
        STK  = 4'd13
    } addrModeT;

    // base cycles per mode, fetch cycle included
    localparam logic [stepW-1:0] cycleCount [14] = '{
        3'd2, 3'd2, 3'd2, 3'd3, 3'd4, 3'd4, 3'd4,
        3'd4, 3'd4, 3'd5, 3'd6, 3'd5, 3'd2, 3'd3
    };

    typedef struct packed {
        logic pcInc;
        logic fetchLo;
        logic fetchHi;
        logic indexAdd;
        logic memRead;
        logic memWrite;
        logic lastCycle;
    } ctrlFlagsT;

endpackage
